// File: rtl/l1d_cfg.svh
// sizes of the L1 data cache
// the buffer and queue depths must be powers of two
`ifndef L1D_CFG_SVH
`define L1D_CFG_SVH

`define L1D_ADDR_BITS    16
`define L1D_WORD_BITS    64
`define L1D_LINE_WORDS   4
`define L1D_LINES        16
`define L1D_OFFSET_BITS  5
`define L1D_INDEX_BITS   4
`define L1D_TAG_BITS     6
`define L1D_REQ_CREDITS  4
`define L1D_MSHRS        2
`define L1D_MSHR_DEPTH   4
`define L1D_RESP_DEPTH   4

`endif

// File: rtl/l1d_pkg.sv
// request, response and lower cache types shared by the L1 data cache
// addresses are physical byte addresses, words are 64-bit aligned
`include "l1d_cfg.svh"

package l1d_pkg;

  typedef logic [`L1D_ADDR_BITS-`L1D_OFFSET_BITS-1:0] l1d_laddr_t;
  typedef logic [`L1D_LINE_WORDS*`L1D_WORD_BITS-1:0] l1d_line_t;
  typedef logic [$clog2(`L1D_LINE_WORDS)-1:0] l1d_woff_t;

  typedef struct packed {
    logic                        we;
    logic [`L1D_ADDR_BITS-1:0]   addr;
    logic [`L1D_WORD_BITS-1:0]   data;
    logic [`L1D_TAG_BITS-1:0]    tag;
  } l1d_req_t;

  // request after address split, also the MSHR queue entry
  typedef struct packed {
    logic                        we;
    l1d_laddr_t                  line_addr;
    logic [`L1D_INDEX_BITS-1:0]  index;
    l1d_woff_t                   word;
    logic [`L1D_WORD_BITS-1:0]   data;
    logic [`L1D_TAG_BITS-1:0]    tag;
  } l1d_dreq_t;

  typedef struct packed {
    logic [`L1D_TAG_BITS-1:0]    tag;
    logic                        we;
    logic [`L1D_WORD_BITS-1:0]   data;
  } l1d_resp_t;

  typedef struct packed {
    logic                        we;
    l1d_laddr_t                  line_addr;
    l1d_line_t                   line;
  } l1d_lc_req_t;

  typedef struct packed {
    l1d_laddr_t                  line_addr;
    l1d_line_t                   line;
  } l1d_fill_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_READ,
    ST_EVICT,
    ST_FILL,
    ST_REPLAY
  } l1d_state_e;

endpackage

// File: rtl/l1d_req_decode.sv
// credit-backed request buffer, one entry per credit
// a credit comes back in the same cycle the controller pops the head
`timescale 1ns/1ns
`include "l1d_cfg.svh"

module l1d_req_decode import l1d_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      req_valid,
  input  l1d_req_t  req,
  input  logic      pop,
  output logic      head_valid,
  output l1d_dreq_t head,
  output logic      req_credit
);
  localparam int PTR_BITS = $clog2(`L1D_REQ_CREDITS);

  l1d_dreq_t buf_q [`L1D_REQ_CREDITS];
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [PTR_BITS:0] count_q;
  l1d_dreq_t dec;

  // split the byte address once, on the way in
  always_comb begin
    dec.we = req.we;
    dec.line_addr = req.addr[`L1D_ADDR_BITS-1:`L1D_OFFSET_BITS];
    dec.index = req.addr[`L1D_OFFSET_BITS+`L1D_INDEX_BITS-1:`L1D_OFFSET_BITS];
    dec.word = req.addr[`L1D_OFFSET_BITS-1:$clog2(`L1D_WORD_BITS/8)];
    dec.data = req.data;
    dec.tag = req.tag;
  end

  always_ff @(posedge clk_in) begin
    if (req_valid) begin
      buf_q[wr_ptr_q] <= dec;
    end
  end

  always_ff @(posedge clk_in or posedge rst_in) begin
    if (rst_in) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({req_valid, pop})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  assign head_valid = (count_q != '0);
  assign head = buf_q[rd_ptr_q];
  assign req_credit = pop;

  // the LSU spent a credit it did not hold
  a_no_overflow: assert property (@(posedge clk_in) disable iff (rst_in)
    req_valid |-> count_q != (PTR_BITS+1)'(`L1D_REQ_CREDITS));
  a_no_underflow: assert property (@(posedge clk_in) disable iff (rst_in)
    pop |-> head_valid);
endmodule

// File: rtl/l1d_line_store.sv
// direct-mapped tag, state and data arrays with combinational read
// word writes and fills both land at most once per cycle
`timescale 1ns/1ns
`include "l1d_cfg.svh"

module l1d_line_store import l1d_pkg::*; (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic [`L1D_INDEX_BITS-1:0]  rd_index,
  input  logic                        wr_en,
  input  l1d_woff_t                   wr_offset,
  input  logic [`L1D_WORD_BITS-1:0]   wr_data,
  input  logic                        fill_en,
  input  l1d_fill_t                   fill_line,
  output logic                        line_valid,
  output logic                        line_dirty,
  output l1d_laddr_t                  line_tag_addr,
  output l1d_line_t                   line_data
);
  localparam int CTAG_BITS = $bits(l1d_laddr_t) - `L1D_INDEX_BITS;

  logic [`L1D_LINES-1:0] valid_q;
  logic [`L1D_LINES-1:0] dirty_q;
  logic [CTAG_BITS-1:0] tag_q [`L1D_LINES];
  l1d_line_t data_q [`L1D_LINES];
  logic [`L1D_INDEX_BITS-1:0] fill_index;

  assign fill_index = fill_line.line_addr[`L1D_INDEX_BITS-1:0];

  always_ff @(posedge clk_in or posedge rst_in) begin
    if (rst_in) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_en) begin
      valid_q[fill_index] <= 1'b1;
      dirty_q[fill_index] <= 1'b0;
    end else if (wr_en) begin
      dirty_q[rd_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (fill_en) begin
      tag_q[fill_index] <= fill_line.line_addr[$bits(l1d_laddr_t)-1:`L1D_INDEX_BITS];
      data_q[fill_index] <= fill_line.line;
    end else if (wr_en) begin
      data_q[rd_index][wr_offset*`L1D_WORD_BITS +: `L1D_WORD_BITS] <= wr_data;
    end
  end

  assign line_valid = valid_q[rd_index];
  assign line_dirty = dirty_q[rd_index];
  // full line address of the resident line, index bits come from the read port
  assign line_tag_addr = {tag_q[rd_index], rd_index};
  assign line_data = data_q[rd_index];

  a_no_write_during_fill: assert property (@(posedge clk_in) disable iff (rst_in)
    !(wr_en && fill_en));
endmodule

// File: rtl/l1d_mshr_file.sv
// miss status holding registers, each one line address plus an in-order queue
// an MSHR stays valid exactly while its queue holds entries
// enq and deq never target the same MSHR in one cycle
`timescale 1ns/1ns
`include "l1d_cfg.svh"

module l1d_mshr_file import l1d_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_in,
  input  l1d_laddr_t lookup_line,
  input  logic       enq,
  input  l1d_dreq_t  enq_req,
  input  l1d_laddr_t fill_line,
  input  logic       deq,
  output logic       match,
  output logic       match_full,
  output logic       free_avail,
  output logic       fill_head_valid,
  output l1d_dreq_t  fill_head
);
  localparam int M = `L1D_MSHRS;
  localparam int D = `L1D_MSHR_DEPTH;
  localparam int QP = $clog2(D);
  localparam int MI = $clog2(M);

  logic [M-1:0] valid_q;
  l1d_laddr_t line_q [M];
  l1d_dreq_t q_mem [M][D];
  logic [QP-1:0] head_q [M];
  logic [QP:0] cnt_q [M];
  logic [M-1:0] hit_vec;
  logic [M-1:0] fhit_vec;
  logic [MI-1:0] hit_idx;
  logic [MI-1:0] free_idx;
  logic [MI-1:0] fill_idx;
  logic [MI-1:0] enq_idx;
  logic dup;

  // descending scan so the lowest free MSHR wins
  always_comb begin
    hit_idx = '0;
    free_idx = '0;
    fill_idx = '0;
    for (int i = M - 1; i >= 0; i--) begin
      hit_vec[i] = valid_q[i] && (line_q[i] == lookup_line);
      fhit_vec[i] = valid_q[i] && (line_q[i] == fill_line);
      if (hit_vec[i]) begin
        hit_idx = MI'(i);
      end
      if (fhit_vec[i]) begin
        fill_idx = MI'(i);
      end
      if (!valid_q[i]) begin
        free_idx = MI'(i);
      end
    end
  end

  assign match = |hit_vec;
  assign match_full = (cnt_q[hit_idx] == (QP+1)'(D));
  assign free_avail = ~&valid_q;
  assign enq_idx = match ? hit_idx : free_idx;
  assign fill_head_valid = |fhit_vec;
  assign fill_head = q_mem[fill_idx][head_q[fill_idx]];

  always_ff @(posedge clk_in) begin
    if (enq) begin
      q_mem[enq_idx][head_q[enq_idx] + cnt_q[enq_idx][QP-1:0]] <= enq_req;
      if (!match) begin
        line_q[enq_idx] <= enq_req.line_addr;
      end
    end
  end

  always_ff @(posedge clk_in or posedge rst_in) begin
    if (rst_in) begin
      valid_q <= '0;
      for (int i = 0; i < M; i++) begin
        head_q[i] <= '0;
        cnt_q[i] <= '0;
      end
    end else begin
      if (enq) begin
        valid_q[enq_idx] <= 1'b1;
        cnt_q[enq_idx] <= cnt_q[enq_idx] + 1'b1;
      end
      if (deq) begin
        head_q[fill_idx] <= head_q[fill_idx] + 1'b1;
        cnt_q[fill_idx] <= cnt_q[fill_idx] - 1'b1;
        // last waiter leaves, MSHR is free again
        if (cnt_q[fill_idx] == (QP+1)'(1)) begin
          valid_q[fill_idx] <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    dup = 1'b0;
    for (int i = 0; i < M; i++) begin
      for (int j = i + 1; j < M; j++) begin
        if (valid_q[i] && valid_q[j] && (line_q[i] == line_q[j])) begin
          dup = 1'b1;
        end
      end
    end
  end

  // secondary misses must merge, never open a second MSHR for a line
  a_unique_lines: assert property (@(posedge clk_in) disable iff (rst_in) !dup);
endmodule

// File: rtl/l1d_ctrl.sv
// cache controller, one request or one fill handled per step
// a pending fill takes priority over the request at the buffer head
// replayed requests are applied to the line that was just installed
`timescale 1ns/1ns
`include "l1d_cfg.svh"

module l1d_ctrl import l1d_pkg::*; (
  input  logic                        clk_in,
  input  logic                        rst_in,
  input  logic                        head_valid,
  input  l1d_dreq_t                   head,
  input  logic                        line_valid,
  input  logic                        line_dirty,
  input  l1d_laddr_t                  line_tag_addr,
  input  l1d_line_t                   line_data,
  input  logic                        match,
  input  logic                        match_full,
  input  logic                        free_avail,
  input  logic                        fill_head_valid,
  input  l1d_dreq_t                   fill_head,
  input  logic                        resp_full,
  input  logic                        lc_req_ready,
  input  logic                        lc_fill_valid,
  input  l1d_fill_t                   lc_fill,
  output logic                        pop,
  output logic [`L1D_INDEX_BITS-1:0]  rd_index,
  output logic                        wr_en,
  output l1d_woff_t                   wr_offset,
  output logic [`L1D_WORD_BITS-1:0]   wr_data,
  output logic                        fill_en,
  output l1d_fill_t                   fill_line,
  output logic                        enq,
  output l1d_dreq_t                   enq_req,
  output l1d_laddr_t                  mshr_fill_line,
  output logic                        deq,
  output logic                        push,
  output l1d_resp_t                   push_resp,
  output logic                        lc_req_valid,
  output l1d_lc_req_t                 lc_req,
  output logic                        lc_fill_ready
);
  l1d_state_e state_q;
  l1d_state_e state_d;
  l1d_fill_t fill_q;
  l1d_laddr_t read_line_q;
  l1d_dreq_t cur;
  logic hit;
  logic victim_wb;

  // the request being served, from the buffer or from the MSHR queue
  assign cur = (state_q == ST_REPLAY) ? fill_head : head;
  assign hit = line_valid && (line_tag_addr == head.line_addr);
  assign victim_wb = line_valid && line_dirty && (line_tag_addr != lc_fill.line_addr);

  always_comb begin
    if (state_q == ST_IDLE) begin
      rd_index = lc_fill_valid ? lc_fill.line_addr[`L1D_INDEX_BITS-1:0] : head.index;
    end else begin
      rd_index = fill_q.line_addr[`L1D_INDEX_BITS-1:0];
    end
  end

  always_comb begin
    state_d = state_q;
    pop = 1'b0;
    wr_en = 1'b0;
    fill_en = 1'b0;
    enq = 1'b0;
    deq = 1'b0;
    push = 1'b0;
    lc_fill_ready = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (lc_fill_valid) begin
          lc_fill_ready = 1'b1;
          state_d = victim_wb ? ST_EVICT : ST_FILL;
        end else if (head_valid) begin
          if (hit) begin
            // hits need a response slot now
            pop = !resp_full;
            push = !resp_full;
            wr_en = !resp_full && head.we;
          end else if (match) begin
            pop = !match_full;
            enq = !match_full;
          end else if (free_avail) begin
            pop = 1'b1;
            enq = 1'b1;
            state_d = ST_SEND_READ;
          end
        end
      end
      ST_SEND_READ: begin
        if (lc_req_ready) begin
          state_d = ST_IDLE;
        end
      end
      ST_EVICT: begin
        if (lc_req_ready) begin
          state_d = ST_FILL;
        end
      end
      ST_FILL: begin
        fill_en = 1'b1;
        state_d = ST_REPLAY;
      end
      ST_REPLAY: begin
        if (!fill_head_valid) begin
          state_d = ST_IDLE;
        end else if (!resp_full) begin
          deq = 1'b1;
          push = 1'b1;
          wr_en = fill_head.we;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_in or posedge rst_in) begin
    if (rst_in) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_in) begin
    if (lc_fill_ready) begin
      fill_q <= lc_fill;
    end
    // primary miss, remember which line to read
    if (enq && !match) begin
      read_line_q <= head.line_addr;
    end
  end

  assign wr_offset = cur.word;
  assign wr_data = cur.data;
  assign push_resp.tag = cur.tag;
  assign push_resp.we = cur.we;
  assign push_resp.data = cur.we ? '0 : line_data[cur.word*`L1D_WORD_BITS +: `L1D_WORD_BITS];

  assign enq_req = head;
  assign fill_line = fill_q;
  assign mshr_fill_line = fill_q.line_addr;

  assign lc_req_valid = (state_q == ST_SEND_READ) || (state_q == ST_EVICT);

  // victim line is read from the store, which is untouched during eviction
  always_comb begin
    lc_req.we = (state_q == ST_EVICT);
    lc_req.line_addr = (state_q == ST_EVICT) ? line_tag_addr : read_line_q;
    lc_req.line = (state_q == ST_EVICT) ? line_data : '0;
  end

  a_lc_req_stable: assert property (@(posedge clk_in) disable iff (rst_in)
    lc_req_valid && !lc_req_ready |=> lc_req_valid && $stable(lc_req));
endmodule

// File: rtl/l1d_resp_queue.sv
// response FIFO towards the LSU, the head is held until it is taken
`timescale 1ns/1ns
`include "l1d_cfg.svh"

module l1d_resp_queue import l1d_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      push,
  input  l1d_resp_t push_resp,
  input  logic      resp_ready,
  output logic      full,
  output logic      resp_valid,
  output l1d_resp_t resp
);
  localparam int PTR_BITS = $clog2(`L1D_RESP_DEPTH);

  l1d_resp_t mem_q [`L1D_RESP_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr_q;
  logic [PTR_BITS-1:0] rd_ptr_q;
  logic [PTR_BITS:0] count_q;
  logic take;

  assign take = resp_valid && resp_ready;

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_resp;
    end
  end

  always_ff @(posedge clk_in or posedge rst_in) begin
    if (rst_in) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (take) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, take})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  assign full = (count_q == (PTR_BITS+1)'(`L1D_RESP_DEPTH));
  assign resp_valid = (count_q != '0);
  assign resp = mem_q[rd_ptr_q];

  a_no_push_full: assert property (@(posedge clk_in) disable iff (rst_in) push |-> !full);
endmodule

// File: rtl/l1d_cache.sv
// non-blocking write-back L1 data cache, direct-mapped
// LSU requests use credits, responses and the lower cache use valid/ready
`timescale 1ns/1ns
`include "l1d_cfg.svh"

module l1d_cache import l1d_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_in,
  input  logic        req_valid,
  input  l1d_req_t    req,
  output logic        req_credit,
  output logic        resp_valid,
  output l1d_resp_t   resp,
  input  logic        resp_ready,
  output logic        lc_req_valid,
  output l1d_lc_req_t lc_req,
  input  logic        lc_req_ready,
  input  logic        lc_fill_valid,
  input  l1d_fill_t   lc_fill,
  output logic        lc_fill_ready
);
  logic head_valid;
  l1d_dreq_t head;
  logic pop;
  logic [`L1D_INDEX_BITS-1:0] rd_index;
  logic wr_en;
  l1d_woff_t wr_offset;
  logic [`L1D_WORD_BITS-1:0] wr_data;
  logic fill_en;
  l1d_fill_t fill_line;
  logic line_valid;
  logic line_dirty;
  l1d_laddr_t line_tag_addr;
  l1d_line_t line_data;
  logic enq;
  l1d_dreq_t enq_req;
  l1d_laddr_t mshr_fill_line;
  logic deq;
  logic match;
  logic match_full;
  logic free_avail;
  logic fill_head_valid;
  l1d_dreq_t fill_head;
  logic push;
  l1d_resp_t push_resp;
  logic resp_full;

  l1d_req_decode u_req_decode (
    .clk_in, .rst_in, .req_valid, .req, .pop, .head_valid, .head, .req_credit
  );

  l1d_line_store u_line_store (
    .clk_in, .rst_in, .rd_index, .wr_en, .wr_offset, .wr_data, .fill_en, .fill_line,
    .line_valid, .line_dirty, .line_tag_addr, .line_data
  );

  l1d_mshr_file u_mshr_file (
    .clk_in, .rst_in, .lookup_line(head.line_addr), .enq, .enq_req,
    .fill_line(mshr_fill_line), .deq, .match, .match_full, .free_avail,
    .fill_head_valid, .fill_head
  );

  l1d_ctrl u_ctrl (
    .clk_in, .rst_in, .head_valid, .head, .line_valid, .line_dirty, .line_tag_addr,
    .line_data, .match, .match_full, .free_avail, .fill_head_valid, .fill_head,
    .resp_full, .lc_req_ready, .lc_fill_valid, .lc_fill, .pop, .rd_index, .wr_en,
    .wr_offset, .wr_data, .fill_en, .fill_line, .enq, .enq_req, .mshr_fill_line,
    .deq, .push, .push_resp, .lc_req_valid, .lc_req, .lc_fill_ready
  );

  l1d_resp_queue u_resp_queue (
    .clk_in, .rst_in, .push, .push_resp, .resp_ready, .full(resp_full),
    .resp_valid, .resp
  );
endmodule

// File: verif/l1d_cache_tb.sv
// random traffic into the L1 data cache, checked against a flat word memory model
// requests stay in a 2 KB region so that four lines alias each cache index
// the LC model returns fills after random delays, possibly out of order
`timescale 1ns/1ns
`include "l1d_cfg.svh"

module l1d_cache_tb import l1d_pkg::*; ();
  localparam int NUM_REQS = 2000;
  localparam int MAX_CYCLES = 40 * NUM_REQS;
  localparam int WORDS = 256;
  localparam int LINES = WORDS / `L1D_LINE_WORDS;
  localparam int TAGS = 1 << `L1D_TAG_BITS;
  localparam int WB = `L1D_WORD_BITS;

  logic clk_in;
  logic rst_in;
  logic req_valid;
  l1d_req_t req;
  logic req_credit;
  logic resp_valid;
  l1d_resp_t resp;
  logic resp_ready;
  logic lc_req_valid;
  l1d_lc_req_t lc_req;
  logic lc_req_ready;
  logic lc_fill_valid;
  l1d_fill_t lc_fill;
  logic lc_fill_ready;

  logic [31:0] lfsr_q;
  logic [WB-1:0] backing_mem [WORDS];
  logic [WB-1:0] ref_mem [WORDS];
  int pend_wr [WORDS];
  logic [LINES-1:0] filled;
  logic [LINES-1:0] has_write;
  logic [LINES-1:0] read_pending;
  logic [TAGS-1:0] outstanding;
  logic exp_we [TAGS];
  logic [WB-1:0] exp_data [TAGS];
  logic [7:0] exp_word [TAGS];
  // reads accepted by the LC model and not yet filled
  logic [5:0] fq_line [$];
  int fq_wait [$];
  int credits;
  int issued;
  int n_out;
  int n_resp;
  int errors;
  int cycles;
  logic [`L1D_TAG_BITS-1:0] next_tag;
  logic resp_hold;
  logic lc_hold;
  logic fill_done;
  l1d_resp_t prev_resp;
  l1d_lc_req_t prev_lc_req;

  l1d_cache u_dut (
    .clk_in, .rst_in, .req_valid, .req, .req_credit, .resp_valid, .resp, .resp_ready,
    .lc_req_valid, .lc_req, .lc_req_ready, .lc_fill_valid, .lc_fill, .lc_fill_ready
  );

  initial clk_in = 1'b0;
  always #20 clk_in = ~clk_in;

  // galois LFSR with taps x^32 + x^30 + x^26 + x^25 + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic flag_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // all inputs change on the falling edge
  task automatic drive_inputs();
    logic [7:0] widx;
    logic we;
    logic [WB-1:0] data;
    int pick;
    req_valid = 1'b0;
    // a tag is reused only once its previous response is back
    if (issued < NUM_REQS && credits > 0 && !outstanding[next_tag]) begin
      if (take_bits(2) != 0) begin
        widx = 8'(take_bits(8));
        we = take_bits(1) != 0;
        data = '0;
        if (we) begin
          data = take_bits(64);
        end
        req.we = we;
        req.addr = {5'b0, widx, 3'b000};
        req.data = data;
        req.tag = next_tag;
        req_valid = 1'b1;
        exp_we[next_tag] = we;
        exp_word[next_tag] = widx;
        exp_data[next_tag] = we ? '0 : ref_mem[widx];
        if (we) begin
          ref_mem[widx] = data;
          pend_wr[widx]++;
          has_write[widx[7:2]] = 1'b1;
        end
        outstanding[next_tag] = 1'b1;
        credits--;
        n_out++;
        issued++;
        next_tag++;
      end
    end
    resp_ready = take_bits(2) != 0;
    lc_req_ready = take_bits(1) != 0;
    for (int i = 0; i < fq_wait.size(); i++) begin
      if (fq_wait[i] > 0) begin
        fq_wait[i]--;
      end
    end
    // a fill stays on the port until it is accepted
    if (!lc_fill_valid || fill_done) begin
      lc_fill_valid = 1'b0;
      pick = -1;
      for (int i = 0; i < fq_wait.size(); i++) begin
        if (pick < 0 && fq_wait[i] == 0) begin
          pick = i;
        end
      end
      if (pick >= 0) begin
        lc_fill_valid = 1'b1;
        lc_fill.line_addr = l1d_laddr_t'(fq_line[pick]);
        for (int w = 0; w < `L1D_LINE_WORDS; w++) begin
          lc_fill.line[w*WB +: WB] = backing_mem[{fq_line[pick], w[1:0]}];
        end
        fq_line.delete(pick);
        fq_wait.delete(pick);
      end
    end
    fill_done = 1'b0;
  endtask

  // outputs are settled here and transfer on the next rising edge
  task automatic sample_outputs();
    logic [7:0] widx;
    logic [5:0] lidx;
    if (req_credit) begin
      credits++;
      assert (credits <= `L1D_REQ_CREDITS)
        else flag_failure($sformatf("at %0t ns the cache returned a credit it never lent", $time));
    end
    if (resp_hold) begin
      assert (resp_valid && resp == prev_resp)
        else flag_failure($sformatf("at %0t ns the response changed before it was taken", $time));
    end
    resp_hold = resp_valid && !resp_ready;
    prev_resp = resp;
    if (resp_valid && resp_ready) begin
      assert (outstanding[resp.tag])
        else flag_failure($sformatf("at %0t ns tag %0d answered with no request pending",
          $time, resp.tag));
      if (outstanding[resp.tag]) begin
        assert (resp.we == exp_we[resp.tag] && resp.data == exp_data[resp.tag])
          else flag_failure($sformatf(
            "Error at %0t ns: tag %0d gave we=%0b data=%h, expected we=%0b data=%h",
            $time, resp.tag, resp.we, resp.data, exp_we[resp.tag], exp_data[resp.tag]));
        if (exp_we[resp.tag]) begin
          pend_wr[exp_word[resp.tag]]--;
        end
        outstanding[resp.tag] = 1'b0;
        n_out--;
        n_resp++;
      end
    end
    if (lc_hold) begin
      assert (lc_req_valid && lc_req == prev_lc_req)
        else flag_failure($sformatf("at %0t ns the LC request changed before it was taken", $time));
    end
    lc_hold = lc_req_valid && !lc_req_ready;
    prev_lc_req = lc_req;
    if (lc_req_valid && lc_req_ready) begin
      lidx = lc_req.line_addr[5:0];
      assert (lc_req.line_addr < LINES)
        else flag_failure($sformatf("at %0t ns the LC saw a line outside the test region", $time));
      if (!lc_req.we) begin
        assert (!read_pending[lidx])
          else flag_failure($sformatf("at %0t ns line %0d was read again before its fill",
            $time, lidx));
        read_pending[lidx] = 1'b1;
        fq_line.push_back(lidx);
        fq_wait.push_back(int'(take_bits(4)));
      end else begin
        assert (filled[lidx] && has_write[lidx])
          else flag_failure($sformatf(
            "at %0t ns line %0d was written back but never filled and written",
            $time, lidx));
        for (int w = 0; w < `L1D_LINE_WORDS; w++) begin
          widx = {lidx, w[1:0]};
          backing_mem[widx] = lc_req.line[w*WB +: WB];
          // a word with a write still in flight may hold either value
          if (pend_wr[widx] == 0) begin
            assert (backing_mem[widx] == ref_mem[widx])
              else flag_failure($sformatf("Error at %0t ns: writeback word %0d is %h, expected %h",
                $time, widx, backing_mem[widx], ref_mem[widx]));
          end
        end
      end
    end
    if (lc_fill_valid && lc_fill_ready) begin
      lidx = lc_fill.line_addr[5:0];
      filled[lidx] = 1'b1;
      read_pending[lidx] = 1'b0;
      fill_done = 1'b1;
    end
  endtask

  initial begin
    lfsr_q = 32'h2027_7eee;
    rst_in = 1'b1;
    req_valid = 1'b0;
    req = '0;
    resp_ready = 1'b0;
    lc_req_ready = 1'b0;
    lc_fill_valid = 1'b0;
    lc_fill = '0;
    // every word starts out as its own byte address
    for (int i = 0; i < WORDS; i++) begin
      backing_mem[i] = WB'(i * 8);
      ref_mem[i] = WB'(i * 8);
      pend_wr[i] = 0;
    end
    filled = '0;
    has_write = '0;
    read_pending = '0;
    outstanding = '0;
    credits = `L1D_REQ_CREDITS;
    issued = 0;
    n_out = 0;
    n_resp = 0;
    errors = 0;
    next_tag = '0;
    resp_hold = 1'b0;
    lc_hold = 1'b0;
    fill_done = 1'b0;
    repeat (3) @(negedge clk_in);
    rst_in = 1'b0;
    while (!(issued == NUM_REQS && n_out == 0 && credits == `L1D_REQ_CREDITS)) begin
      @(negedge clk_in);
      drive_inputs();
      #5;
      sample_outputs();
    end
    // every request is answered, so the cache must stay quiet from here on
    repeat (8) begin
      @(negedge clk_in);
      req_valid = 1'b0;
      resp_ready = 1'b0;
      lc_req_ready = 1'b0;
      lc_fill_valid = 1'b0;
      #5;
      sample_outputs();
      assert (!resp_valid && !lc_req_valid)
        else flag_failure($sformatf(
          "at %0t ns the cache sent a response or LC request with no request left", $time));
    end
    assert (credits == `L1D_REQ_CREDITS && read_pending == '0)
      else flag_failure("credits are missing or an LC read never had its fill accepted");
    $display("%0d requests, %0d responses checked, %0d errors", issued, n_resp, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_in);
      cycles++;
    end
    $display("simulation stopped after %0d cycles with %0d responses still missing",
      cycles, n_out);
    $display("%0d requests, %0d responses checked, %0d errors", issued, n_resp, errors);
    $display("Finished with errors");
    $finish;
  end
endmodule

// File: l1d_cache.f
+incdir+rtl
rtl/l1d_pkg.sv
rtl/l1d_req_decode.sv
rtl/l1d_line_store.sv
rtl/l1d_mshr_file.sv
rtl/l1d_ctrl.sv
rtl/l1d_resp_queue.sv
rtl/l1d_cache.sv
verif/l1d_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the L1 data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module l1d_cache_tb \
  -f l1d_cache.f -o sim_l1d_cache
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_l1d_cache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Finished with no errors$"; then
  exit 0
fi
exit 1
